//--- Makefile
# Verilator build and run for the video generator testbench

VERILATOR ?= verilator
TOP       ?= video_gen_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
design/video_pkg.sv
design/video_timing.sv
design/video_regs.sv
design/video_fetch.sv
design/video_pixel.sv
design/video_gen.sv
verif/video_gen_sva.sv
verif/video_gen_tb.sv

//--- design/video_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module video_fetch (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire video_pkg::timing_beat_t beat_i,
    input  wire video_pkg::pf_cfg_t      cfg_i,
    output logic                         vram_sel_o,
    output video_pkg::addr_t             vram_addr_o,
    output video_pkg::fetch_beat_t       fbeat_o
);

    video_pkg::addr_t line_addr;            // first word of the current display line

    // one word per pixel pair, read on the even pixel
    always_comb begin
        vram_sel_o  = beat_i.h_visible && beat_i.v_visible &&
                      !beat_i.h_count[0] && !cfg_i.blank;
        vram_addr_o = line_addr + video_pkg::addr_t'(beat_i.h_count >> 1);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
        end else if (beat_i.end_of_frame) begin
            line_addr <= cfg_i.start_addr;  // next frame starts over
        end else if (beat_i.end_of_line && beat_i.v_visible) begin
            line_addr <= line_addr + cfg_i.line_len;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fbeat_o <= '0;                  // keeps video outputs dark after reset
        end else begin
            fbeat_o.beat     <= beat_i;
            fbeat_o.fetched  <= vram_sel_o;
            fbeat_o.low_byte <= beat_i.h_count[0];
        end
    end

endmodule

`default_nettype wire

//--- design/video_gen.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                reg_wr_i,       // register write strobe
    input  wire video_pkg::reg_num_t reg_num_i,
    input  wire video_pkg::word_t    reg_data_i,
    output video_pkg::word_t         reg_data_o,
    output video_pkg::intr_t         intr_o,
    output logic                     vram_sel_o,
    output video_pkg::addr_t         vram_addr_o,
    input  wire video_pkg::word_t    vram_data_i,    // one cycle after vram_sel_o
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     dv_de_o,
    output video_pkg::color_t        color_index_o
);

    video_pkg::timing_beat_t beat;
    video_pkg::fetch_beat_t  fbeat;
    video_pkg::pf_cfg_t      cfg;

    video_timing #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) u_timing (
        .clk     (clk),
        .reset_i (reset_i),
        .beat_o  (beat)
    );

    video_regs #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE)
    ) u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .beat_i     (beat),
        .reg_data_o (reg_data_o),
        .intr_o     (intr_o),
        .cfg_o      (cfg)
    );

    video_fetch u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .beat_i      (beat),
        .cfg_i       (cfg),
        .vram_sel_o  (vram_sel_o),
        .vram_addr_o (vram_addr_o),
        .fbeat_o     (fbeat)
    );

    video_pixel u_pixel (
        .clk           (clk),
        .reset_i       (reset_i),
        .fbeat_i       (fbeat),
        .cfg_i         (cfg),
        .vram_data_i   (vram_data_i),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o),
        .color_index_o (color_index_o)
    );

endmodule

`default_nettype wire

//--- design/video_pixel.sv
`default_nettype none
`timescale 1ns/1ps

module video_pixel (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire video_pkg::fetch_beat_t fbeat_i,
    input  wire video_pkg::pf_cfg_t     cfg_i,
    input  wire video_pkg::word_t       vram_data_i,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o,
    output video_pkg::color_t           color_index_o
);

    video_pkg::word_t  word_q;              // word kept for the odd pixel
    video_pkg::color_t data_byte;
    video_pkg::color_t color;
    logic              active;
    logic              in_window;

    always_comb begin
        active    = fbeat_i.beat.h_visible && fbeat_i.beat.v_visible;
        in_window = (fbeat_i.beat.h_count >= cfg_i.vid_left) &&
                    (fbeat_i.beat.h_count <  cfg_i.vid_right);
        data_byte = fbeat_i.low_byte ? word_q[7:0] : vram_data_i[15:8];
        if (!active) begin
            color = '0;
        end else if (cfg_i.blank || !in_window) begin
            color = cfg_i.border;
        end else begin
            color = data_byte ^ cfg_i.colorbase;
        end
    end

    always_ff @(posedge clk) begin
        if (fbeat_i.fetched) begin
            word_q <= vram_data_i;          // read data is valid the cycle after the select
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
            dv_de_o       <= 1'b0;
            color_index_o <= '0;
        end else begin
            hsync_o       <= fbeat_i.beat.hsync;
            vsync_o       <= fbeat_i.beat.vsync;
            dv_de_o       <= active;
            color_index_o <= color;
        end
    end

endmodule

`default_nettype wire

//--- design/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [15:0] word_t;            // memory or register data word
    typedef logic [15:0] addr_t;            // video-RAM word address
    typedef logic [7:0]  color_t;           // palette index
    typedef logic [10:0] hres_t;            // horizontal counter
    typedef logic [10:0] vres_t;            // vertical counter
    typedef logic [4:0]  reg_num_t;         // config register number
    typedef logic [3:0]  intr_t;            // interrupt pulse bits

    // one pixel clock worth of raster timing
    typedef struct packed {
        hres_t  h_count;
        vres_t  v_count;
        logic   h_visible;
        logic   v_visible;
        logic   hsync;
        logic   vsync;
        logic   end_of_line;                // last pixel clock of any line
        logic   end_of_frame;               // last pixel clock of the frame
        logic   end_of_visible;             // last visible pixel of the frame
    } timing_beat_t;

    // playfield and window configuration
    typedef struct packed {
        color_t border;
        color_t colorbase;                  // XOR'd with each data byte
        logic   blank;
        addr_t  start_addr;
        word_t  line_len;                   // words added to line address per line
        hres_t  vid_left;
        hres_t  vid_right;
    } pf_cfg_t;

    typedef struct packed {
        timing_beat_t beat;
        logic         fetched;              // vram read issued for this pixel
        logic         low_byte;             // odd pixel of the pair
    } fetch_beat_t;

    localparam reg_num_t XR_VID_CTRL     = 5'd0;
    localparam reg_num_t XR_VID_LEFT     = 5'd4;
    localparam reg_num_t XR_VID_RIGHT    = 5'd5;
    localparam reg_num_t XR_SCANLINE     = 5'd8;
    localparam reg_num_t XR_VID_HSIZE    = 5'd10;
    localparam reg_num_t XR_VID_VSIZE    = 5'd11;
    localparam reg_num_t XR_PA_GFX_CTRL  = 5'd16;
    localparam reg_num_t XR_PA_DISP_ADDR = 5'd18;
    localparam reg_num_t XR_PA_LINE_LEN  = 5'd19;

    localparam int     VSYNC_INTR   = 3;
    localparam color_t BORDER_RESET = 8'h08;    // dark grey, shows the display is alive

endpackage

`default_nettype wire

//--- design/video_regs.sv
`default_nettype none
`timescale 1ns/1ps

module video_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    reg_wr_i,
    input  wire video_pkg::reg_num_t     reg_num_i,
    input  wire video_pkg::word_t        reg_data_i,
    input  wire video_pkg::timing_beat_t beat_i,
    output video_pkg::word_t             reg_data_o,
    output video_pkg::intr_t             intr_o,
    output video_pkg::pf_cfg_t           cfg_o
);

    video_pkg::word_t rd_data;

    // register writes and interrupt pulses
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o.border     <= video_pkg::BORDER_RESET;
            cfg_o.colorbase  <= '0;
            cfg_o.blank      <= 1'b1;                    // playfield starts blanked
            cfg_o.start_addr <= '0;
            cfg_o.line_len   <= video_pkg::word_t'(H_VISIBLE / 2);
            cfg_o.vid_left   <= '0;
            cfg_o.vid_right  <= video_pkg::hres_t'(H_VISIBLE);
            intr_o           <= '0;
        end else begin
            intr_o <= '0;                                // pulses last one cycle
            if (reg_wr_i) begin
                case (reg_num_i)
                    video_pkg::XR_VID_CTRL: begin
                        cfg_o.border <= reg_data_i[15:8];
                        intr_o       <= reg_data_i[3:0]; // request bits, not stored
                    end
                    video_pkg::XR_VID_LEFT: begin
                        cfg_o.vid_left <= reg_data_i[10:0];
                    end
                    video_pkg::XR_VID_RIGHT: begin
                        cfg_o.vid_right <= reg_data_i[10:0];
                    end
                    video_pkg::XR_PA_GFX_CTRL: begin
                        cfg_o.colorbase <= reg_data_i[15:8];
                        cfg_o.blank     <= reg_data_i[7];
                    end
                    video_pkg::XR_PA_DISP_ADDR: begin
                        cfg_o.start_addr <= reg_data_i;
                    end
                    video_pkg::XR_PA_LINE_LEN: begin
                        cfg_o.line_len <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end
            if (beat_i.end_of_visible) begin
                intr_o[video_pkg::VSYNC_INTR] <= 1'b1;  // vertical blank starts next line
            end
        end
    end

    // read-back mux
    always_comb begin
        case (reg_num_i)
            video_pkg::XR_VID_CTRL:     rd_data = {cfg_o.border, 8'h00};
            video_pkg::XR_VID_LEFT:     rd_data = 16'(cfg_o.vid_left);
            video_pkg::XR_VID_RIGHT:    rd_data = 16'(cfg_o.vid_right);
            video_pkg::XR_SCANLINE:     rd_data = 16'(beat_i.v_count);
            video_pkg::XR_VID_HSIZE:    rd_data = 16'(H_VISIBLE);
            video_pkg::XR_VID_VSIZE:    rd_data = 16'(V_VISIBLE);
            video_pkg::XR_PA_GFX_CTRL:  rd_data = {cfg_o.colorbase, cfg_o.blank, 7'b0};
            video_pkg::XR_PA_DISP_ADDR: rd_data = cfg_o.start_addr;
            video_pkg::XR_PA_LINE_LEN:  rd_data = cfg_o.line_len;
            default:                    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;              // data one cycle after the number
    end

endmodule

`default_nettype wire

//--- design/video_timing.sv
`default_nettype none
`timescale 1ns/1ps

module video_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    output video_pkg::timing_beat_t    beat_o
);

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
    localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

    video_pkg::hres_t h_next;
    video_pkg::vres_t v_next;

    // flags for a counter position, so they are registered together with the counts
    function automatic video_pkg::timing_beat_t decode(input video_pkg::hres_t h,
                                                       input video_pkg::vres_t v);
        video_pkg::timing_beat_t b;
        logic eol;
        eol              = (h == video_pkg::hres_t'(H_TOTAL - 1));
        b.h_count        = h;
        b.v_count        = v;
        b.h_visible      = (h < video_pkg::hres_t'(H_VISIBLE));
        b.v_visible      = (v < video_pkg::vres_t'(V_VISIBLE));
        b.hsync          = (h >= video_pkg::hres_t'(H_SYNC_START)) &&
                           (h <  video_pkg::hres_t'(H_SYNC_START + H_SYNC));
        b.vsync          = (v >= video_pkg::vres_t'(V_SYNC_START)) &&
                           (v <  video_pkg::vres_t'(V_SYNC_START + V_SYNC));
        b.end_of_line    = eol;
        b.end_of_frame   = eol && (v == video_pkg::vres_t'(V_TOTAL - 1));
        b.end_of_visible = (h == video_pkg::hres_t'(H_VISIBLE - 1)) &&
                           (v == video_pkg::vres_t'(V_VISIBLE - 1));
        return b;
    endfunction

    always_comb begin
        h_next = beat_o.h_count + 1'b1;
        v_next = beat_o.v_count;
        if (beat_o.end_of_line) begin
            h_next = '0;
            v_next = beat_o.v_count + 1'b1;
            if (beat_o.end_of_frame) begin
                v_next = '0;                // wrap at V_TOTAL
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            beat_o <= decode('0, '0);       // first beat after reset is h=0, v=0
        end else begin
            beat_o <= decode(h_next, v_next);
        end
    end

endmodule

`default_nettype wire

//--- verif/video_gen_sva.sv
`default_nettype none
`timescale 1ns/1ps

module video_fetch_sva (
    input wire logic                    clk,
    input wire logic                    reset_i,
    input wire video_pkg::timing_beat_t beat_i,
    input wire logic                    vram_sel_o,
    input wire video_pkg::addr_t        vram_addr_o
);

    // the pixel after a read is the odd visible half of the same pair
    sel_on_visible_even: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |=> (beat_i.h_visible && beat_i.h_count[0] && !vram_sel_o))
        else $error("vram select not on the even pixel of a visible pair");

    // next select of a line is two pixels on, one word further
    addr_steps_by_one: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o ##2 vram_sel_o) |-> (vram_addr_o == $past(vram_addr_o, 2) + 16'd1))
        else $error("consecutive vram selects not one word apart");

endmodule

bind video_fetch video_fetch_sva u_fetch_sva (.*);

`default_nettype wire

//--- verif/video_gen_tb.sv
`default_nettype none
`timescale 1ns/1ps

module video_gen_tb;

    localparam int H_VIS   = 16;
    localparam int H_FP    = 2;
    localparam int H_SW    = 2;
    localparam int H_BP    = 4;
    localparam int V_VIS   = 6;
    localparam int V_FP    = 1;
    localparam int V_SW    = 1;
    localparam int V_BP    = 2;
    localparam int H_TOT   = H_VIS + H_FP + H_SW + H_BP;
    localparam int V_TOT   = V_VIS + V_FP + V_SW + V_BP;
    localparam int FRAME   = H_TOT * V_TOT;
    localparam int TIMEOUT = 8 * FRAME + 200;

    typedef struct packed {
        logic              hsync;
        logic              vsync;
        logic              de;
        video_pkg::color_t color;
    } expect_t;

    logic                clk;
    logic                reset_i;
    logic                reg_wr_i;
    video_pkg::reg_num_t reg_num_i;
    video_pkg::word_t    reg_data_i;
    video_pkg::word_t    vram_data_i;
    video_pkg::word_t    reg_data_o;
    video_pkg::intr_t    intr_o;
    logic                vram_sel_o;
    video_pkg::addr_t    vram_addr_o;
    logic                hsync_o;
    logic                vsync_o;
    logic                dv_de_o;
    video_pkg::color_t   color_index_o;

    // model of the configuration the DUT should hold
    video_pkg::color_t sh_border;
    video_pkg::color_t sh_colorbase;
    logic              sh_blank;
    video_pkg::addr_t  sh_start;
    video_pkg::word_t  sh_line_len;
    video_pkg::hres_t  sh_left;
    video_pkg::hres_t  sh_right;
    video_pkg::intr_t  wr_intr;             // bits expected from a VID_CTRL write

    int               cyc;                  // beat number, 0 is the first beat after reset
    int               total;
    integer           seed;
    logic             sel_q;
    video_pkg::addr_t addr_q;

    video_gen #(
        .H_VISIBLE (H_VIS),
        .H_FRONT   (H_FP),
        .H_SYNC    (H_SW),
        .H_BACK    (H_BP),
        .V_VISIBLE (V_VIS),
        .V_FRONT   (V_FP),
        .V_SYNC    (V_SW),
        .V_BACK    (V_BP)
    ) uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_i      (reg_wr_i),
        .reg_num_i     (reg_num_i),
        .reg_data_i    (reg_data_i),
        .reg_data_o    (reg_data_o),
        .intr_o        (intr_o),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_i   (vram_data_i),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o),
        .color_index_o (color_index_o)
    );

    always #5 clk = ~clk;

    function automatic video_pkg::word_t vram_word(input video_pkg::addr_t a);
        return (a * 16'd3) ^ 16'h5a3c;
    endfunction

    function automatic video_pkg::addr_t fetch_addr(input int n);
        int h;
        int v;
        h = n % H_TOT;
        v = (n / H_TOT) % V_TOT;
        return sh_start + video_pkg::addr_t'(v) * sh_line_len + video_pkg::addr_t'(h / 2);
    endfunction

    function automatic logic expected_sel(input int n);
        int h;
        int v;
        h = n % H_TOT;
        v = (n / H_TOT) % V_TOT;
        return (h < H_VIS) && (v < V_VIS) && (h % 2 == 0) && !sh_blank;
    endfunction

    function automatic logic is_end_of_visible(input int n);
        return (n % H_TOT == H_VIS - 1) && ((n / H_TOT) % V_TOT == V_VIS - 1);
    endfunction

    // expected video outputs for beat n
    function automatic expect_t ref_pixel(input int n);
        int               h;
        int               v;
        video_pkg::word_t w;
        expect_t          e;
        h       = n % H_TOT;
        v       = (n / H_TOT) % V_TOT;
        e.hsync = (h >= H_VIS + H_FP) && (h < H_VIS + H_FP + H_SW);
        e.vsync = (v >= V_VIS + V_FP) && (v < V_VIS + V_FP + V_SW);
        e.de    = (h < H_VIS) && (v < V_VIS);
        e.color = '0;
        if (e.de) begin
            if (sh_blank || h < int'(sh_left) || h >= int'(sh_right)) begin
                e.color = sh_border;
            end else begin
                w = vram_word(fetch_addr(n));
                e.color = ((h % 2 == 1) ? w[7:0] : w[15:8]) ^ sh_colorbase;  // odd pixel low
            end
        end
        return e;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_color(input string name, input video_pkg::color_t got,
                               input video_pkg::color_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input video_pkg::word_t got,
                              input video_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_intr(input string name, input video_pkg::intr_t got,
                              input video_pkg::intr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // video RAM answers one cycle after the select
    always @(negedge clk) begin
        sel_q  <= vram_sel_o;
        addr_q <= vram_addr_o;
    end

    always @(posedge clk) begin
        #1;
        if (sel_q) begin
            vram_data_i = vram_word(addr_q);
        end
    end

    always @(posedge clk) begin
        total <= total + 1;
        if (!reset_i) begin
            cyc <= cyc + 1;
        end
        if (total >= TIMEOUT) begin
            $display("simulation did not finish within %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    always @(negedge clk) begin : compare_outputs
        expect_t          e;
        video_pkg::intr_t exp_intr;
        if (!reset_i) begin
            if (cyc < 2) begin
                e = '0;                     // pipeline still empty
            end else begin
                e = ref_pixel(cyc - 2);
            end
            check_bit("hsync_o", hsync_o, e.hsync);
            check_bit("vsync_o", vsync_o, e.vsync);
            check_bit("dv_de_o", dv_de_o, e.de);
            check_color("color_index_o", color_index_o, e.color);
            check_bit("vram_sel_o", vram_sel_o, expected_sel(cyc));
            if (vram_sel_o) begin
                check_word("vram_addr_o", vram_addr_o, fetch_addr(cyc));
            end
            exp_intr = wr_intr;
            if (cyc >= 1 && is_end_of_visible(cyc - 1)) begin
                exp_intr[video_pkg::VSYNC_INTR] = 1'b1;
            end
            check_intr("intr_o", intr_o, exp_intr);
            wr_intr = '0;
        end
    end

    task automatic write_reg(input video_pkg::reg_num_t num, input video_pkg::word_t data);
        @(posedge clk);
        #1;
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);                     // write lands on this edge
        case (num)
            video_pkg::XR_VID_CTRL: begin
                sh_border = data[15:8];
                wr_intr   = data[3:0];
            end
            video_pkg::XR_VID_LEFT:     sh_left = data[10:0];
            video_pkg::XR_VID_RIGHT:    sh_right = data[10:0];
            video_pkg::XR_PA_GFX_CTRL: begin
                sh_colorbase = data[15:8];
                sh_blank     = data[7];
            end
            video_pkg::XR_PA_DISP_ADDR: sh_start = data;
            video_pkg::XR_PA_LINE_LEN:  sh_line_len = data;
            default: begin
            end
        endcase
        #1;
        reg_wr_i = 1'b0;
    endtask

    task automatic read_check(input video_pkg::reg_num_t num, input video_pkg::word_t exp);
        @(posedge clk);
        #1;
        reg_num_i = num;
        @(posedge clk);
        @(negedge clk);
        check_word("reg_data_o", reg_data_o, exp);
    endtask

    task automatic read_scanline();
        @(posedge clk);
        #1;
        reg_num_i = video_pkg::XR_SCANLINE;
        @(posedge clk);
        @(negedge clk);
        check_word("reg_data_o", reg_data_o, video_pkg::word_t'(((cyc - 1) / H_TOT) % V_TOT));
    endtask

    task automatic wait_vblank();
        @(negedge clk);
        while (!(((cyc / H_TOT) % V_TOT == V_VIS) && (cyc % H_TOT == 0))) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_cycle(input int n);
        while (cyc < n) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        reg_wr_i     = 1'b0;
        reg_num_i    = '0;
        reg_data_i   = '0;
        vram_data_i  = '0;
        cyc          = 0;
        total        = 0;
        seed         = 32'h9f7d_1845;
        sel_q        = 1'b0;
        addr_q       = '0;
        wr_intr      = '0;
        sh_border    = video_pkg::BORDER_RESET;
        sh_colorbase = '0;
        sh_blank     = 1'b1;
        sh_start     = '0;
        sh_line_len  = video_pkg::word_t'(H_VIS / 2);
        sh_left      = '0;
        sh_right     = video_pkg::hres_t'(H_VIS);

        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("hsync_o", hsync_o, 1'b0);
            check_bit("vsync_o", vsync_o, 1'b0);
            check_bit("dv_de_o", dv_de_o, 1'b0);
            check_bit("vram_sel_o", vram_sel_o, 1'b0);
            check_color("color_index_o", color_index_o, 8'h00);
            check_intr("intr_o", intr_o, 4'h0);
        end
        @(posedge clk);
        #1;
        reset_i = 1'b0;

        // reset values
        read_check(video_pkg::XR_VID_CTRL, 16'h0800);
        read_check(video_pkg::XR_VID_LEFT, 16'd0);
        read_check(video_pkg::XR_VID_RIGHT, 16'(H_VIS));
        read_check(video_pkg::XR_VID_HSIZE, 16'd16);
        read_check(video_pkg::XR_VID_VSIZE, 16'd6);
        read_check(video_pkg::XR_PA_GFX_CTRL, 16'h0080);
        read_check(video_pkg::XR_PA_DISP_ADDR, 16'h0000);
        read_check(video_pkg::XR_PA_LINE_LEN, 16'(H_VIS / 2));
        read_check(5'd1, 16'h0000);         // unlisted register

        wait_cycle(2 * FRAME);              // two blanked frames

        wait_vblank();
        write_reg(video_pkg::XR_PA_DISP_ADDR, video_pkg::word_t'($random(seed)));
        write_reg(video_pkg::XR_PA_LINE_LEN, video_pkg::word_t'($random(seed)));
        write_reg(video_pkg::XR_PA_GFX_CTRL, {8'($random(seed)), 8'h00});

        wait_vblank();                      // one full unblanked frame checked
        write_reg(video_pkg::XR_VID_LEFT, 16'(1 + ($random(seed) & 7)));
        write_reg(video_pkg::XR_VID_RIGHT, 16'(9 + ($random(seed) & 7)));
        write_reg(video_pkg::XR_VID_CTRL, {8'($random(seed)), 8'h05});

        wait_vblank();
        repeat (6) begin
            read_scanline();
            repeat (7 + ($random(seed) & 15)) @(posedge clk);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
